//--- program.hex
// one 32-bit instruction word per line, hex, word address 0 upward
// loop of straight code, forward branch, jal forward and back, backward branch
00100093
00200113
002081b3
00208863
010000ef
00400213
00500293
0100006f
00130313
ff5ff06f
00000013
00138393
0063d463
fc7346e3
00000013
00000013
00000013
00000013
00000013
00000013

//--- fetch_frontend.f
+incdir+.
fetch_pkg.sv
axi_rd_if.sv
ifu.sv
inst_rom.sv
decode_redirect.sv
fetch_frontend.sv
tb_fetch_frontend.sv

//--- tb_fetch_frontend.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"

module tb_fetch_frontend;

	localparam int BEATS = 200;
	localparam int CYCLE_LIMIT = 5 * BEATS * 8;

	logic clk = 1'b0;
	logic rst;
	logic [1:0] mem_delay;
	logic out_ready;
	logic out_valid;
	logic [31:0] out_pc;
	logic [31:0] out_inst;

	logic [31:0] rom_img [0:`ROM_WORDS-1];
	logic [31:0] exp_pc;
	logic [31:0] lfsr_state;
	logic holding;
	logic [31:0] held_pc;
	logic [31:0] held_inst;
	int beat_total;
	int cycle_count = 0;

	fetch_frontend fetch_frontend_i (
		.clk (clk),
		.rst (rst),
		.mem_delay (mem_delay),
		.out_ready (out_ready),
		.out_valid (out_valid),
		.out_pc (out_pc),
		.out_inst (out_inst)
	);

	always #10 clk = ~clk;

	task automatic stop_failed(input string what);
		$display("%s", what);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic value_error(input string what);
		stop_failed($sformatf("ERR %0d ns: %s", $time, what));
	endtask

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count > CYCLE_LIMIT)
			stop_failed($sformatf("run did not finish within %0d cycles", CYCLE_LIMIT));
	end

	// galois form, polynomial x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h8020_0003;
		else
			return s >> 1;
	endfunction

	task automatic rand_bits(input int n, output logic [3:0] val);
		int i;
		val = 4'd0;
		for (i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			val = {val[2:0], lfsr_state[0]};
		end
	endtask

	// predicted successor: jal taken, backward conditional branch taken
	function automatic logic [31:0] next_pc(input logic [31:0] pc, input logic [31:0] w);
		logic [31:0] j_off;
		logic [31:0] b_off;
		j_off = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
		b_off = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
		if (w[6:0] == 7'b1101111)
			return pc + j_off;
		else if (w[6:0] == 7'b1100011 && w[31])
			return pc + b_off;
		else
			return pc + 32'd4;
	endfunction

	task automatic check_beat();
		logic [31:0] exp_inst;
		assert (exp_pc[31:2] < `ROM_WORDS)
			else stop_failed("reference model ran outside the ROM");
		exp_inst = rom_img[exp_pc[31:2]];
		assert (out_pc == exp_pc)
			else value_error($sformatf("beat %0d pc %h, expected %h", beat_total, out_pc, exp_pc));
		assert (out_inst == exp_inst)
			else value_error($sformatf("beat %0d inst %h, expected %h", beat_total, out_inst,
				exp_inst));
		exp_pc = next_pc(exp_pc, exp_inst);
		beat_total++;
	endtask

	// look at the outputs mid cycle, return just after the next rising edge
	task automatic watch_cycle(output bit beat);
		beat = 1'b0;
		@(negedge clk);
		if (out_valid) begin
			if (holding) begin
				assert (out_pc == held_pc && out_inst == held_inst)
					else value_error($sformatf("output moved while stalled, pc %h -> %h",
						held_pc, out_pc));
			end
			if (out_ready) begin
				check_beat();
				beat = 1'b1;
				holding = 1'b0;
			end else begin
				holding = 1'b1;
				held_pc = out_pc;
				held_inst = out_inst;
			end
		end else begin
			assert (!holding)
				else value_error("out_valid dropped before the beat was taken");
		end
		@(posedge clk);
	endtask

	task automatic apply_reset();
		int i;
		rst <= 1'b1;
		for (i = 0; i < 10; i++) begin
			@(posedge clk);
			// tenth reset edge, released from here on
			if (i == 9)
				rst <= 1'b0;
			@(negedge clk);
			assert (!out_valid)
				else value_error("out_valid high during reset");
		end
		@(posedge clk);
		exp_pc = `FLASH_START;
		holding = 1'b0;
	endtask

	task automatic run_stream(input int n, input bit rand_ready, input bit rand_delay);
		int beats;
		bit beat;
		logic [3:0] r;
		beats = 0;
		while (beats < n) begin
			watch_cycle(beat);
			if (beat) begin
				beats++;
				if (rand_delay) begin
					rand_bits(2, r);
					mem_delay <= r[1:0];
				end
			end
			if (rand_ready) begin
				rand_bits(1, r);
				out_ready <= r[0];
			end
		end
	endtask

	task automatic zero_delay_test();
		$display("zero delay stream");
		mem_delay <= 2'd0;
		out_ready <= 1'b1;
		apply_reset();
		run_stream(BEATS, 1'b0, 1'b0);
	endtask

	task automatic slow_memory_test();
		$display("three cycle memory delay");
		mem_delay <= 2'd3;
		out_ready <= 1'b1;
		apply_reset();
		run_stream(BEATS, 1'b0, 1'b0);
	endtask

	task automatic backpressure_test();
		$display("random back-pressure");
		mem_delay <= 2'd1;
		out_ready <= 1'b1;
		apply_reset();
		run_stream(BEATS, 1'b1, 1'b0);
	endtask

	task automatic varying_delay_test();
		$display("memory delay changing per beat");
		mem_delay <= 2'd2;
		out_ready <= 1'b1;
		apply_reset();
		run_stream(BEATS, 1'b0, 1'b1);
	endtask

	task automatic midrun_reset_test();
		$display("reset in the middle of a stream");
		mem_delay <= 2'd1;
		out_ready <= 1'b1;
		apply_reset();
		run_stream(70, 1'b1, 1'b1);
		// stream has to start over from the reset pc
		apply_reset();
		run_stream(BEATS, 1'b1, 1'b1);
	endtask

	initial begin
		rst = 1'b1;
		mem_delay = 2'd0;
		out_ready = 1'b0;
		lfsr_state = 32'ha033_31e7;
		holding = 1'b0;
		beat_total = 0;
		exp_pc = `FLASH_START;
		$readmemh("program.hex", rom_img);
		zero_delay_test();
		slow_memory_test();
		backpressure_test();
		varying_delay_test();
		midrun_reset_test();
		$display("%0d beats checked in %0d cycles", beat_total, cycle_count);
		$display("Test OK");
		$finish;
	end

endmodule

//--- fetch_frontend.sv
`timescale 1ns/1ps

module fetch_frontend (
	input logic clk,
	input logic rst,
	input logic [1:0] mem_delay,
	input logic out_ready,
	output logic out_valid,
	output logic [31:0] out_pc,
	output logic [31:0] out_inst
);

	logic flush;
	logic [31:0] flush_target;
	logic inst_valid;
	logic inst_ready;
	logic [31:0] inst;
	logic [31:0] pc;

	axi_rd_if rd_bus ();

	ifu ifu_i (
		.clk (clk),
		.rst (rst),
		.flush (flush),
		.flush_target (flush_target),
		.inst_ready (inst_ready),
		.mem (rd_bus.master),
		.pc (pc),
		.inst (inst),
		.inst_valid (inst_valid)
	);

	inst_rom inst_rom_i (
		.clk (clk),
		.rst (rst),
		.mem_delay (mem_delay),
		.bus (rd_bus.slave)
	);

	decode_redirect decode_redirect_i (
		.clk (clk),
		.rst (rst),
		.inst_valid (inst_valid),
		.inst (inst),
		.pc (pc),
		.out_ready (out_ready),
		.inst_ready (inst_ready),
		.out_valid (out_valid),
		.out_pc (out_pc),
		.out_inst (out_inst),
		.flush (flush),
		.flush_target (flush_target)
	);

endmodule

//--- decode_redirect.sv
`timescale 1ns/1ps

module decode_redirect import fetch_pkg::*; (
	input logic clk,
	input logic rst,
	input logic inst_valid,
	input logic [31:0] inst,
	input logic [31:0] pc,
	input logic out_ready,
	output logic inst_ready,
	output logic out_valid,
	output logic [31:0] out_pc,
	output logic [31:0] out_inst,
	output logic flush,
	output logic [31:0] flush_target
);

	rv_inst_u iw;
	logic [31:0] j_imm;
	logic [31:0] b_imm;
	logic is_jal;
	logic is_bwd_branch;
	logic take;
	logic accept;
	logic [31:0] target;

	assign iw = inst;

	// same word through both layouts
	assign j_imm = {{11{iw.j.imm20}}, iw.j.imm20, iw.j.imm19_12, iw.j.imm11,
		iw.j.imm10_1, 1'b0};
	assign b_imm = {{19{iw.b.imm12}}, iw.b.imm12, iw.b.imm11, iw.b.imm10_5,
		iw.b.imm4_1, 1'b0};

	// static prediction, jal always, branches only backward
	assign is_jal = (iw.j.opcode == OP_JAL);
	assign is_bwd_branch = (iw.b.opcode == OP_BRANCH) && iw.b.imm12;
	assign take = is_jal || is_bwd_branch;
	assign target = pc + (is_jal ? j_imm : b_imm);

	// single entry, refills in the cycle it drains
	assign inst_ready = !out_valid || out_ready;
	assign accept = inst_valid && inst_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
			flush <= 1'b0;
		end else begin
			if (inst_ready)
				out_valid <= inst_valid;
			flush <= accept && take;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			out_pc <= pc;
			out_inst <= inst;
			flush_target <= target;
		end
	end

	// ifu holds inst_valid low during flush, so no back to back redirect
	a_flush_pulse: assert property (@(posedge clk) disable iff (rst)
		flush |=> !flush);

endmodule

//--- inst_rom.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"

module inst_rom (
	input logic clk,
	input logic rst,
	input logic [1:0] mem_delay,
	axi_rd_if.slave bus
);

	localparam int IDX_W = $clog2(`ROM_WORDS);

	logic [31:0] rom [0:`ROM_WORDS-1];
	logic busy;
	logic [1:0] wait_cnt;
	logic [31:0] addr_q;
	logic [31:0] rd_addr;
	logic [IDX_W-1:0] word_idx;
	logic in_range;

	initial begin
		$readmemh("program.hex", rom);
	end

	// one read at a time
	assign bus.arready = !busy;

	// idle answers straight from the request, busy from the held address
	assign rd_addr = busy ? addr_q : bus.araddr;
	assign word_idx = rd_addr[IDX_W+1:2];
	assign in_range = (rd_addr[31:2] < `ROM_WORDS);

	assign bus.rvalid = busy ? (wait_cnt == 2'd0) : (bus.arvalid && mem_delay == 2'd0);
	assign bus.rdata = in_range ? rom[word_idx] : 32'd0;
	assign bus.rresp = in_range ? `OKAY : `SLVERR;

	always_ff @(posedge clk) begin
		if (rst) begin
			busy <= 1'b0;
			wait_cnt <= 2'd0;
		end else if (!busy) begin
			// zero delay reads taken at once do not occupy the rom
			if (bus.arvalid && !(bus.rvalid && bus.rready)) begin
				busy <= 1'b1;
				wait_cnt <= (mem_delay == 2'd0) ? 2'd0 : mem_delay - 2'd1;
			end
		end else if (wait_cnt != 2'd0) begin
			wait_cnt <= wait_cnt - 2'd1;
		end else if (bus.rready) begin
			busy <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (!busy && bus.arvalid)
			addr_q <= bus.araddr;
	end

	// response held steady until the master takes it
	a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
		bus.rvalid && !bus.rready |=> bus.rvalid && $stable(bus.rdata));

endmodule

//--- ifu.sv
`timescale 1ns/1ps
`include "fetch_settings.svh"

module ifu (
	input logic clk,
	input logic rst,
	input logic flush,
	input logic [31:0] flush_target,
	input logic inst_ready,
	axi_rd_if.master mem,
	output logic [31:0] pc,
	output logic [31:0] inst,
	output logic inst_valid
);

	localparam logic [1:0] WAIT_MMEM_READY = 2'd0;
	localparam logic [1:0] WAIT_MMEM_REQ = 2'd1;
	localparam logic [1:0] WAIT_IDU_READY = 2'd2;

	logic [1:0] state;
	logic [31:0] inst_q;
	logic flush_pending;
	logic [31:0] pending_target;
	logic fast_rsp;
	logic capture_flush;

	// data returned in the same cycle the address is taken
	assign fast_rsp = (state == WAIT_MMEM_READY) && mem.arready && mem.rvalid;

	// flush seen while a read is still outstanding
	assign capture_flush = flush &&
		((state == WAIT_MMEM_READY && mem.arready && !mem.rvalid) ||
		 (state == WAIT_MMEM_REQ));

	assign mem.araddr = pc;
	assign mem.arvalid = (state == WAIT_MMEM_READY);
	assign mem.rready = (state == WAIT_MMEM_REQ) ||
		(state == WAIT_MMEM_READY && mem.arready);

	// wrong-path words never go to decode
	assign inst_valid = ((state == WAIT_IDU_READY) || fast_rsp) && !flush && !flush_pending;
	assign inst = fast_rsp ? mem.rdata : inst_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= WAIT_MMEM_READY;
			pc <= `FLASH_START;
			flush_pending <= 1'b0;
		end else begin
			case (state)
				WAIT_MMEM_READY: begin
					if (!mem.arready) begin
						// address not taken yet, just retarget
						if (flush)
							pc <= flush_target;
					end else if (mem.rvalid) begin
						if (flush) begin
							pc <= flush_target;
						end else if (inst_ready) begin
							pc <= pc + 32'd4;
						end else begin
							state <= WAIT_IDU_READY;
						end
					end else begin
						if (flush)
							flush_pending <= 1'b1;
						state <= WAIT_MMEM_REQ;
					end
				end
				WAIT_MMEM_REQ: begin
					if (flush)
						flush_pending <= 1'b1;
					if (mem.rvalid)
						state <= WAIT_IDU_READY;
				end
				WAIT_IDU_READY: begin
					// a fresh flush beats the one recorded earlier
					if (flush) begin
						pc <= flush_target;
						flush_pending <= 1'b0;
						state <= WAIT_MMEM_READY;
					end else if (flush_pending) begin
						pc <= pending_target;
						flush_pending <= 1'b0;
						state <= WAIT_MMEM_READY;
					end else if (inst_ready) begin
						pc <= pc + 32'd4;
						state <= WAIT_MMEM_READY;
					end
				end
				default: state <= WAIT_MMEM_READY;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (mem.rvalid && mem.rready)
			inst_q <= mem.rdata;
		if (capture_flush)
			pending_target <= flush_target;
	end

	// rom only gets in-range addresses on the predicted path
	a_rresp_okay: assert property (@(posedge clk) disable iff (rst)
		mem.rvalid && mem.rready |-> mem.rresp == `OKAY);

endmodule

//--- axi_rd_if.sv
`timescale 1ns/1ps

interface axi_rd_if;
	// read address channel
	logic [31:0] araddr;
	logic arvalid;
	logic arready;

	// read data channel
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;

	modport master (
		output araddr, arvalid, rready,
		input arready, rdata, rresp, rvalid
	);

	modport slave (
		input araddr, arvalid, rready,
		output arready, rdata, rresp, rvalid
	);

endinterface

//--- fetch_pkg.sv
package fetch_pkg;

	// major opcodes checked by decode
	localparam logic [6:0] OP_JAL = 7'b1101111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;

	// jal layout, immediate bits scattered
	typedef struct packed {
		logic imm20;
		logic [9:0] imm10_1;
		logic imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_type_t;

	// conditional branch layout
	typedef struct packed {
		logic imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic imm11;
		logic [6:0] opcode;
	} b_type_t;

	// one word, two views
	typedef union packed {
		j_type_t j;
		b_type_t b;
	} rv_inst_u;

endpackage

//--- fetch_settings.svh
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// pc after reset
`define FLASH_START 32'h0000_0000

// read response codes
`define OKAY 2'b00
`define SLVERR 2'b10

// rom size in 32-bit words
`define ROM_WORDS 64

`endif
